//--- sim.f
+incdir+testbench
hw/plru_geom_pkg.sv
hw/plru_tree_pkg.sv
hw/plru_bit_store.sv
hw/plru_bus_arbiter.sv
hw/plru_hit_update.sv
hw/plru_victim_select.sv
hw/plru_top.sv
testbench/plru_tb.sv

//--- testbench/plru_model.svh
//////////////////////////////////////////////////
// Reference model for the PLRU testbench
// Random generator, per-line trees, touch and
// victim rules, blocked-way rule
//////////////////////////////////////////////////

int unsigned rng_state = 32'h9c60b53d;

// One tree per cache line starting at zero like the store
logic [NUM_WAYS-2:0] model_tree [NUM_LINES] = '{default: '0};

// Linear congruential generator
function automatic int unsigned rand_u32();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
endfunction

function automatic logic [NUM_WAYS-1:0] rand_mask();
    return NUM_WAYS'(rand_u32() >> 16);
endfunction

function automatic int rand_way();
    return int'((rand_u32() >> 16) % NUM_WAYS);
endfunction

function automatic int rand_index();
    return int'((rand_u32() >> 16) % NUM_LINES);
endfunction

// Sparse lock set that never covers every way
function automatic logic [NUM_WAYS-1:0] sparse_lock();
    logic [NUM_WAYS-1:0] lock;
    lock = rand_mask() & rand_mask();
    if (&lock) begin
        lock[rand_way()] = 1'b0;
    end
    return lock;
endfunction

// Occupied ways are out while a free way is left
// A full set leaves out only the locked ways
function automatic logic [NUM_WAYS-1:0] blocked_mask(
    input logic [NUM_WAYS-1:0] valid,
    input logic [NUM_WAYS-1:0] lock
);
    logic [NUM_WAYS-1:0] res;
    logic                any_free;
    int                  w;
    any_free = 1'b0;
    for (w = 0; w < NUM_WAYS; w++) begin
        if (!valid[w] && !lock[w]) begin
            any_free = 1'b1;
        end
    end
    for (w = 0; w < NUM_WAYS; w++) begin
        res[w] = lock[w] || (any_free && valid[w]);
    end
    return res;
endfunction

// Nodes on the way's path point at the other half
function automatic logic [NUM_WAYS-2:0] model_touch(
    input logic [NUM_WAYS-2:0] word,
    input int                  way
);
    logic [NUM_WAYS-2:0] w;
    int                  node;
    int                  lvl;
    logic                upper;
    w    = word;
    node = 0;
    for (lvl = 0; lvl < TREE_LEVELS; lvl++) begin
        upper   = ((way >> (TREE_LEVELS - 1 - lvl)) & 1) == 1;
        w[node] = upper;
        node    = upper ? 2 * node + 1 : 2 * node + 2;
    end
    return w;
endfunction

// Walk by way-index prefix and skip a fully blocked half
function automatic int model_victim(
    input logic [NUM_WAYS-2:0] word,
    input logic [NUM_WAYS-1:0] blocked
);
    int   prefix;
    int   node;
    int   lvl;
    int   w;
    int   shift;
    logic up_free;
    logic lo_free;
    logic go_up;
    prefix = 0;
    node   = 0;
    for (lvl = 0; lvl < TREE_LEVELS; lvl++) begin
        shift   = TREE_LEVELS - 1 - lvl;
        up_free = 1'b0;
        lo_free = 1'b0;
        for (w = 0; w < NUM_WAYS; w++) begin
            if ((w >> shift) == 2 * prefix + 1 && !blocked[w]) begin
                up_free = 1'b1;
            end
            if ((w >> shift) == 2 * prefix && !blocked[w]) begin
                lo_free = 1'b1;
            end
        end
        if (up_free != lo_free) begin
            go_up = up_free;
        end else begin
            go_up = (word[node] == 1'b0);
        end
        prefix = 2 * prefix + int'(go_up);
        node   = go_up ? 2 * node + 1 : 2 * node + 2;
    end
    return prefix;
endfunction

//--- testbench/plru_tb.sv
//////////////////////////////////////////////////
// Testbench for the PLRU replacement unit
// Clock, reset, random hit and evict traffic,
// model compare, watchdog and final report
//////////////////////////////////////////////////

`timescale 1ns/1ns

module plru_tb
    import plru_geom_pkg::*;
;

    localparam int NUM_WAYS     = NUM_WAYS_DEF;
    localparam int NUM_LINES    = NUM_LINES_DEF;
    localparam int IDX_W        = $clog2(NUM_LINES);
    localparam int TREE_LEVELS  = $clog2(NUM_WAYS);
    localparam int RESET_CYCLES = 16;
    localparam int SEQ_ITERS    = 40;
    localparam int SEQ_HITS     = 3;
    localparam int N_FREE       = 40;
    localparam int N_LOCK       = 40;
    localparam int N_CONC       = 40;
    localparam int TOTAL_OPS    = 1 + SEQ_ITERS * (SEQ_HITS + 1) + 2 * (N_FREE + N_LOCK + N_CONC);
    localparam int CYCLE_LIMIT  = 20 * TOTAL_OPS + RESET_CYCLES;
    localparam int OP_WAIT      = 40;

    logic                clk_i = 1'b0;
    logic                arst_n_i;
    logic                hit_i;
    logic [IDX_W-1:0]    hit_index_i;
    logic [NUM_WAYS-1:0] hit_way_i;
    logic                hit_done_o;
    logic                evict_i;
    logic [IDX_W-1:0]    evict_index_i;
    logic [NUM_WAYS-1:0] tag_valid_i;
    logic [NUM_WAYS-1:0] tag_dirty_i;
    logic [NUM_WAYS-1:0] spm_lock_i;
    logic                victim_valid_o;
    logic [NUM_WAYS-1:0] victim_way_o;
    logic                evict_o;

    int                  value_errs = 0;
    int                  other_errs = 0;
    int                  cycle_cnt = 0;
    logic                hit_pending;
    logic                evict_pending;
    int                  hit_way_idx;
    logic [NUM_WAYS-1:0] last_victim;

    `include "plru_model.svh"

    plru_top #(.NUM_WAYS(NUM_WAYS), .NUM_LINES(NUM_LINES)) i_plru_top (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .hit_i          (hit_i),
        .hit_index_i    (hit_index_i),
        .hit_way_i      (hit_way_i),
        .hit_done_o     (hit_done_o),
        .evict_i        (evict_i),
        .evict_index_i  (evict_index_i),
        .tag_valid_i    (tag_valid_i),
        .tag_dirty_i    (tag_dirty_i),
        .spm_lock_i     (spm_lock_i),
        .victim_valid_o (victim_valid_o),
        .victim_way_o   (victim_way_o),
        .evict_o        (evict_o)
    );

    always #50 clk_i = ~clk_i;

    task automatic report_and_finish(input logic timed_out);
        $display("Value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // Watchdog on the whole run
    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout: run still busy after %0d cycles", cycle_cnt);
            report_and_finish(1'b1);
        end
    end

    task automatic check_way(
        input string               name,
        input logic [NUM_WAYS-1:0] got,
        input logic [NUM_WAYS-1:0] exp
    );
        if (got !== exp) begin
            $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            value_errs++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            value_errs++;
        end
    endtask

    // One cycle: sample outputs at the falling edge, apply completions to the model
    task automatic step();
        logic [NUM_WAYS-1:0] blk;
        int                  vic;
        @(negedge clk_i);
        if (hit_done_o) begin
            if (!hit_pending) begin
                $display("Hit done pulse at %0t with no hit request outstanding", $time);
                other_errs++;
            end else begin
                model_tree[hit_index_i] = model_touch(model_tree[hit_index_i], hit_way_idx);
                hit_pending = 1'b0;
                hit_i       = 1'b0;
            end
        end
        if (victim_valid_o) begin
            if (!evict_pending) begin
                $display("Victim valid pulse at %0t with no evict request outstanding", $time);
                other_errs++;
            end else begin
                blk = blocked_mask(tag_valid_i, spm_lock_i);
                vic = model_victim(model_tree[evict_index_i], blk);
                check_way("victim_way_o", victim_way_o, NUM_WAYS'(1) << vic);
                check_flag("evict_o", evict_o, tag_dirty_i[vic]);
                if ((victim_way_o & blk) != '0) begin
                    $display("Victim at %0t landed on a way that should be avoided", $time);
                    other_errs++;
                end
                model_tree[evict_index_i] = model_touch(model_tree[evict_index_i], vic);
                last_victim   = victim_way_o;
                evict_pending = 1'b0;
                evict_i       = 1'b0;
            end
        end else begin
            check_way("victim_way_o", victim_way_o, '0);
            check_flag("evict_o", evict_o, 1'b0);
        end
    endtask

    task automatic issue_hit(input int idx, input int way);
        hit_index_i = IDX_W'(idx);
        hit_way_i   = NUM_WAYS'(1) << way;
        hit_way_idx = way;
        hit_i       = 1'b1;
        hit_pending = 1'b1;
    endtask

    task automatic issue_evict(
        input int                  idx,
        input logic [NUM_WAYS-1:0] valid,
        input logic [NUM_WAYS-1:0] dirty,
        input logic [NUM_WAYS-1:0] lock
    );
        evict_index_i = IDX_W'(idx);
        tag_valid_i   = valid;
        tag_dirty_i   = dirty;
        spm_lock_i    = lock;
        evict_i       = 1'b1;
        evict_pending = 1'b1;
    endtask

    // Run until every outstanding request has completed
    task automatic wait_done();
        int waited;
        waited = 0;
        while ((hit_pending || evict_pending) && waited < OP_WAIT) begin
            step();
            waited++;
        end
        if (hit_pending) begin
            $display("No hit done pulse within %0d cycles of the request", OP_WAIT);
            other_errs++;
            hit_pending = 1'b0;
            hit_i       = 1'b0;
        end
        if (evict_pending) begin
            $display("No victim valid pulse within %0d cycles of the request", OP_WAIT);
            other_errs++;
            evict_pending = 1'b0;
            evict_i       = 1'b0;
        end
    endtask

    initial begin : stimulus
        int                  i;
        int                  k;
        int                  idx;
        int                  hidx;
        int                  way;
        int unsigned         r;
        logic [NUM_WAYS-1:0] valid;
        logic [NUM_WAYS-1:0] dirty;
        logic [NUM_WAYS-1:0] lock;
        arst_n_i      = 1'b0;
        hit_i         = 1'b0;
        hit_index_i   = '0;
        hit_way_i     = '0;
        evict_i       = 1'b0;
        evict_index_i = '0;
        tag_valid_i   = '0;
        tag_dirty_i   = '0;
        spm_lock_i    = '0;
        hit_pending   = 1'b0;
        evict_pending = 1'b0;
        hit_way_idx   = 0;
        last_victim   = '0;
        if (NUM_WAYS < MIN_WAYS || NUM_WAYS > MAX_WAYS || (NUM_WAYS & (NUM_WAYS - 1)) != 0) begin
            $display("Way count %0d is not a power of two in the legal range", NUM_WAYS);
            other_errs++;
        end

        // Outputs must stay quiet through reset and while idle
        repeat (RESET_CYCLES) step();
        arst_n_i = 1'b1;
        repeat (4) step();

        // Fresh line with every way free goes to the top way
        dirty = rand_mask();
        issue_evict(0, '0, dirty, '0);
        wait_done();
        check_way("victim_way_o", last_victim, NUM_WAYS'(1) << (NUM_WAYS - 1));

        // Hit sequences, then eviction from a full unlocked set
        for (i = 0; i < SEQ_ITERS; i++) begin
            idx = rand_index();
            for (k = 0; k < SEQ_HITS; k++) begin
                way = rand_way();
                step();
                issue_hit(idx, way);
                wait_done();
            end
            dirty = rand_mask();
            step();
            issue_evict(idx, '1, dirty, '0);
            wait_done();
        end

        // Some ways unoccupied
        for (i = 0; i < N_FREE; i++) begin
            idx = rand_index();
            way = rand_way();
            step();
            issue_hit(idx, way);
            wait_done();
            valid = rand_mask();
            lock  = sparse_lock();
            if (&(valid | lock)) begin
                way        = rand_way();
                valid[way] = 1'b0;
                lock[way]  = 1'b0;
            end
            dirty = rand_mask();
            step();
            issue_evict(idx, valid, dirty, lock);
            wait_done();
        end

        // Full set with scratchpad ways locked
        for (i = 0; i < N_LOCK; i++) begin
            idx = rand_index();
            way = rand_way();
            step();
            issue_hit(idx, way);
            wait_done();
            lock  = sparse_lock();
            dirty = rand_mask();
            step();
            issue_evict(idx, '1, dirty, lock);
            wait_done();
        end

        // Overlapping hit and evict, sometimes on the same line
        for (i = 0; i < N_CONC; i++) begin
            idx   = rand_index();
            r     = rand_u32();
            hidx  = (r[21:20] == 2'd0) ? idx : rand_index();
            way   = rand_way();
            valid = rand_mask() | rand_mask();
            dirty = rand_mask();
            lock  = sparse_lock();
            step();
            if (r[22]) begin
                issue_evict(idx, valid, dirty, lock);
                repeat (r[25:24]) step();
                issue_hit(hidx, way);
            end else begin
                issue_hit(hidx, way);
                repeat (r[25:24]) step();
                issue_evict(idx, valid, dirty, lock);
            end
            wait_done();
        end

        repeat (4) step();
        report_and_finish(1'b0);
    end

endmodule

//--- hw/plru_top.sv
//////////////////////////////////////////////////
// PLRU replacement unit top level
// Hit updater and victim selector share the bit
// store through a Wishbone classic arbiter
//////////////////////////////////////////////////

`timescale 1ns/1ns

// NUM_WAYS must be a power of two from MIN_WAYS to MAX_WAYS
module plru_top
    import plru_geom_pkg::*;
#(
    parameter int unsigned NUM_WAYS  = NUM_WAYS_DEF,
    parameter int unsigned NUM_LINES = NUM_LINES_DEF
) (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    // Hit side
    input  logic                         hit_i,
    input  logic [$clog2(NUM_LINES)-1:0] hit_index_i,
    input  logic [NUM_WAYS-1:0]          hit_way_i,
    output logic                         hit_done_o,
    // Miss side
    input  logic                         evict_i,
    input  logic [$clog2(NUM_LINES)-1:0] evict_index_i,
    input  logic [NUM_WAYS-1:0]          tag_valid_i,
    input  logic [NUM_WAYS-1:0]          tag_dirty_i,
    input  logic [NUM_WAYS-1:0]          spm_lock_i,
    output logic                         victim_valid_o,
    output logic [NUM_WAYS-1:0]          victim_way_o,
    output logic                         evict_o
);

    localparam int unsigned IDX_W  = $clog2(NUM_LINES);
    localparam int unsigned WORD_W = NUM_WAYS - 1;

    // Hit updater bus
    logic              hu_cyc, hu_stb, hu_we, hu_ack;
    logic [IDX_W-1:0]  hu_adr;
    logic [WORD_W-1:0] hu_dat_w, hu_dat_r;
    // Victim selector bus
    logic              vs_cyc, vs_stb, vs_we, vs_ack;
    logic [IDX_W-1:0]  vs_adr;
    logic [WORD_W-1:0] vs_dat_w, vs_dat_r;
    // Store bus
    logic              st_cyc, st_stb, st_we, st_ack;
    logic [IDX_W-1:0]  st_adr;
    logic [WORD_W-1:0] st_dat_w, st_dat_r;

    plru_hit_update #(.NUM_WAYS(NUM_WAYS), .NUM_LINES(NUM_LINES)) i_hit_update (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .hit_i       (hit_i),
        .hit_index_i (hit_index_i),
        .hit_way_i   (hit_way_i),
        .hit_done_o  (hit_done_o),
        .cyc_o       (hu_cyc),
        .stb_o       (hu_stb),
        .we_o        (hu_we),
        .adr_o       (hu_adr),
        .dat_o       (hu_dat_w),
        .dat_i       (hu_dat_r),
        .ack_i       (hu_ack)
    );

    plru_victim_select #(.NUM_WAYS(NUM_WAYS), .NUM_LINES(NUM_LINES)) i_victim_select (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .evict_i        (evict_i),
        .evict_index_i  (evict_index_i),
        .tag_valid_i    (tag_valid_i),
        .tag_dirty_i    (tag_dirty_i),
        .spm_lock_i     (spm_lock_i),
        .victim_valid_o (victim_valid_o),
        .victim_way_o   (victim_way_o),
        .evict_o        (evict_o),
        .cyc_o          (vs_cyc),
        .stb_o          (vs_stb),
        .we_o           (vs_we),
        .adr_o          (vs_adr),
        .dat_o          (vs_dat_w),
        .dat_i          (vs_dat_r),
        .ack_i          (vs_ack)
    );

    plru_bus_arbiter #(.NUM_WAYS(NUM_WAYS), .NUM_LINES(NUM_LINES)) i_bus_arbiter (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .m0_cyc_i (hu_cyc),
        .m0_stb_i (hu_stb),
        .m0_we_i  (hu_we),
        .m0_adr_i (hu_adr),
        .m0_dat_i (hu_dat_w),
        .m0_dat_o (hu_dat_r),
        .m0_ack_o (hu_ack),
        .m1_cyc_i (vs_cyc),
        .m1_stb_i (vs_stb),
        .m1_we_i  (vs_we),
        .m1_adr_i (vs_adr),
        .m1_dat_i (vs_dat_w),
        .m1_dat_o (vs_dat_r),
        .m1_ack_o (vs_ack),
        .s_cyc_o  (st_cyc),
        .s_stb_o  (st_stb),
        .s_we_o   (st_we),
        .s_adr_o  (st_adr),
        .s_dat_o  (st_dat_w),
        .s_dat_i  (st_dat_r),
        .s_ack_i  (st_ack)
    );

    plru_bit_store #(.NUM_WAYS(NUM_WAYS), .NUM_LINES(NUM_LINES)) i_bit_store (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .cyc_i    (st_cyc),
        .stb_i    (st_stb),
        .we_i     (st_we),
        .adr_i    (st_adr),
        .dat_i    (st_dat_w),
        .dat_o    (st_dat_r),
        .ack_o    (st_ack)
    );

endmodule

//--- hw/plru_victim_select.sv
//////////////////////////////////////////////////
// Victim selector for cache misses
// Picks the eviction way, reports dirtiness,
// then touches the tree with the victim
//////////////////////////////////////////////////

`timescale 1ns/1ns

module plru_victim_select
    import plru_tree_pkg::*;
#(
    parameter int unsigned NUM_WAYS,
    parameter int unsigned NUM_LINES
) (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         evict_i,
    input  logic [$clog2(NUM_LINES)-1:0] evict_index_i,
    input  logic [NUM_WAYS-1:0]          tag_valid_i,
    input  logic [NUM_WAYS-1:0]          tag_dirty_i,
    input  logic [NUM_WAYS-1:0]          spm_lock_i,
    output logic                         victim_valid_o,
    output logic [NUM_WAYS-1:0]          victim_way_o,
    output logic                         evict_o,
    // Wishbone master
    output logic                         cyc_o,
    output logic                         stb_o,
    output logic                         we_o,
    output logic [$clog2(NUM_LINES)-1:0] adr_o,
    output logic [NUM_WAYS-2:0]          dat_o,
    input  logic [NUM_WAYS-2:0]          dat_i,
    input  logic                         ack_i
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_READ  = 2'd1;
    localparam logic [1:0] S_WRITE = 2'd2;
    localparam logic [1:0] S_DONE  = 2'd3;

    logic [1:0]            state_q;
    logic [NUM_WAYS-1:0]   occupied;
    logic [NUM_WAYS-1:0]   blocked;
    logic [TREE_WAYS-1:0]  victim;
    logic [TREE_NODES-1:0] touched;
    logic [NUM_WAYS-1:0]   victim_q;
    logic [NUM_WAYS-2:0]   word_q;

    // Free ways first; with a full set only scratchpad ways are avoided
    assign occupied = tag_valid_i | spm_lock_i;
    assign blocked  = (&occupied) ? spm_lock_i : occupied;

    assign victim  = tree_victim(TREE_NODES'(dat_i), TREE_WAYS'(blocked), NUM_WAYS);
    assign touched = tree_touch(TREE_NODES'(dat_i), victim, NUM_WAYS);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (evict_i) begin
                        state_q <= S_READ;
                    end
                end
                S_READ: begin
                    if (ack_i) begin
                        state_q <= S_WRITE;
                    end
                end
                S_WRITE: begin
                    if (ack_i) begin
                        state_q <= S_DONE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // Victim and updated tree taken together from the read data
    always_ff @(posedge clk_i) begin
        if (state_q == S_READ && ack_i) begin
            victim_q <= victim[NUM_WAYS-1:0];
            word_q   <= touched[NUM_WAYS-2:0];
        end
    end

    assign cyc_o = (state_q == S_READ) || (state_q == S_WRITE);
    assign stb_o = cyc_o;
    assign we_o  = (state_q == S_WRITE);
    assign adr_o = evict_index_i;
    assign dat_o = word_q;

    // Result is zero outside the completion pulse
    assign victim_valid_o = (state_q == S_DONE);
    assign victim_way_o   = victim_valid_o ? victim_q : '0;
    assign evict_o        = victim_valid_o & (|(victim_q & tag_dirty_i));

endmodule

//--- hw/plru_hit_update.sv
//////////////////////////////////////////////////
// Hit updater, read-modify-write of a line's tree
// Moves the tree away from the way that was hit
//////////////////////////////////////////////////

`timescale 1ns/1ns

module plru_hit_update
    import plru_tree_pkg::*;
#(
    parameter int unsigned NUM_WAYS,
    parameter int unsigned NUM_LINES
) (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         hit_i,
    input  logic [$clog2(NUM_LINES)-1:0] hit_index_i,
    input  logic [NUM_WAYS-1:0]          hit_way_i,
    output logic                         hit_done_o,
    // Wishbone master
    output logic                         cyc_o,
    output logic                         stb_o,
    output logic                         we_o,
    output logic [$clog2(NUM_LINES)-1:0] adr_o,
    output logic [NUM_WAYS-2:0]          dat_o,
    input  logic [NUM_WAYS-2:0]          dat_i,
    input  logic                         ack_i
);

    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_READ  = 2'd1;
    localparam logic [1:0] S_WRITE = 2'd2;
    localparam logic [1:0] S_DONE  = 2'd3;

    logic [1:0]            state_q;
    logic [NUM_WAYS-2:0]   word_q;
    logic [TREE_NODES-1:0] touched;

    // Touch works on the read data as it arrives with ack
    assign touched = tree_touch(TREE_NODES'(dat_i), TREE_WAYS'(hit_way_i), NUM_WAYS);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (hit_i) begin
                        state_q <= S_READ;
                    end
                end
                S_READ: begin
                    if (ack_i) begin
                        state_q <= S_WRITE;
                    end
                end
                S_WRITE: begin
                    if (ack_i) begin
                        state_q <= S_DONE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == S_READ && ack_i) begin
            word_q <= touched[NUM_WAYS-2:0];
        end
    end

    // cyc spans read and write so the update is atomic
    assign cyc_o      = (state_q == S_READ) || (state_q == S_WRITE);
    assign stb_o      = cyc_o;
    assign we_o       = (state_q == S_WRITE);
    assign adr_o      = hit_index_i;
    assign dat_o      = word_q;
    assign hit_done_o = (state_q == S_DONE);

endmodule

//--- hw/plru_bus_arbiter.sv
//////////////////////////////////////////////////
// Two-master Wishbone classic arbiter
// Grant held for the whole cycle, ties alternate
//////////////////////////////////////////////////

`timescale 1ns/1ns

module plru_bus_arbiter #(
    parameter int unsigned NUM_WAYS,
    parameter int unsigned NUM_LINES
) (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    // Master 0, hit updater
    input  logic                         m0_cyc_i,
    input  logic                         m0_stb_i,
    input  logic                         m0_we_i,
    input  logic [$clog2(NUM_LINES)-1:0] m0_adr_i,
    input  logic [NUM_WAYS-2:0]          m0_dat_i,
    output logic [NUM_WAYS-2:0]          m0_dat_o,
    output logic                         m0_ack_o,
    // Master 1, victim selector
    input  logic                         m1_cyc_i,
    input  logic                         m1_stb_i,
    input  logic                         m1_we_i,
    input  logic [$clog2(NUM_LINES)-1:0] m1_adr_i,
    input  logic [NUM_WAYS-2:0]          m1_dat_i,
    output logic [NUM_WAYS-2:0]          m1_dat_o,
    output logic                         m1_ack_o,
    // Store side
    output logic                         s_cyc_o,
    output logic                         s_stb_o,
    output logic                         s_we_o,
    output logic [$clog2(NUM_LINES)-1:0] s_adr_o,
    output logic [NUM_WAYS-2:0]          s_dat_o,
    input  logic [NUM_WAYS-2:0]          s_dat_i,
    input  logic                         s_ack_i
);

    logic [1:0] gnt_q;
    logic [1:0] gnt;
    logic       last_q;

    // A held grant wins, an idle bus grants in the same cycle
    always_comb begin
        if (gnt_q != 2'b00) begin
            gnt = gnt_q;
        end else if (m0_cyc_i && m1_cyc_i) begin
            gnt = last_q ? 2'b01 : 2'b10;
        end else begin
            gnt = {m1_cyc_i, m0_cyc_i};
        end
    end

    // Reset marks master 1 as last, so the hit side takes the first tie
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            gnt_q  <= 2'b00;
            last_q <= 1'b1;
        end else begin
            gnt_q <= gnt & {m1_cyc_i, m0_cyc_i};
            if (gnt != 2'b00) begin
                last_q <= gnt[1];
            end
        end
    end

    assign s_cyc_o = (gnt[0] & m0_cyc_i) | (gnt[1] & m1_cyc_i);
    assign s_stb_o = (gnt[0] & m0_stb_i) | (gnt[1] & m1_stb_i);
    assign s_we_o  = gnt[1] ? m1_we_i  : m0_we_i;
    assign s_adr_o = gnt[1] ? m1_adr_i : m0_adr_i;
    assign s_dat_o = gnt[1] ? m1_dat_i : m0_dat_i;

    // Responses reach the granted master only
    assign m0_ack_o = gnt[0] & s_ack_i;
    assign m1_ack_o = gnt[1] & s_ack_i;
    assign m0_dat_o = gnt[0] ? s_dat_i : '0;
    assign m1_dat_o = gnt[1] ? s_dat_i : '0;

endmodule

//--- hw/plru_bit_store.sv
//////////////////////////////////////////////////
// PLRU word storage, one tree per cache line
// Wishbone classic slave, ack one cycle after stb
//////////////////////////////////////////////////

`timescale 1ns/1ns

module plru_bit_store #(
    parameter int unsigned NUM_WAYS,
    parameter int unsigned NUM_LINES
) (
    input  logic                         clk_i,
    input  logic                         arst_n_i,
    input  logic                         cyc_i,
    input  logic                         stb_i,
    input  logic                         we_i,
    input  logic [$clog2(NUM_LINES)-1:0] adr_i,
    input  logic [NUM_WAYS-2:0]          dat_i,
    output logic [NUM_WAYS-2:0]          dat_o,
    output logic                         ack_o
);

    logic [NUM_WAYS-2:0] mem [NUM_LINES];
    logic                access;

    // First stb cycle of a transfer, the ack cycle closes it
    assign access = cyc_i & stb_i & ~ack_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o <= 1'b0;
            mem   <= '{default: '0};
        end else begin
            ack_o <= access;
            if (access && we_i) begin
                mem[adr_i] <= dat_i;
            end
        end
    end

    // Read data lines up with ack
    always_ff @(posedge clk_i) begin
        if (access && !we_i) begin
            dat_o <= mem[adr_i];
        end
    end

endmodule

//--- hw/plru_tree_pkg.sv
//////////////////////////////////////////////////
// PLRU tree encoding and tree functions
// Node pointer values, touch and victim walk
// Nodes in heap order: upper child 2n+1, lower 2n+2
//////////////////////////////////////////////////

package plru_tree_pkg;

    // Node bit as seen by the victim walk
    localparam logic PTR_UPPER = 1'b0;
    localparam logic PTR_LOWER = 1'b1;

    // Functions work on the widest tree and take the real way count
    localparam int unsigned TREE_WAYS  = plru_geom_pkg::MAX_WAYS;
    localparam int unsigned TREE_NODES = TREE_WAYS - 1;
    localparam int unsigned TREE_DEPTH = $clog2(TREE_WAYS);

    // Mask of len ways starting at way lo
    function automatic logic [TREE_WAYS-1:0] way_range(
        input int unsigned lo,
        input int unsigned len
    );
        logic [TREE_WAYS-1:0] ones;
        ones = (TREE_WAYS'(1) << len) - TREE_WAYS'(1);
        return ones << lo;
    endfunction

    // Point every node on the path of way_oh away from that way
    function automatic logic [TREE_NODES-1:0] tree_touch(
        input logic [TREE_NODES-1:0] word,
        input logic [TREE_WAYS-1:0]  way_oh,
        input int unsigned           num_ways
    );
        logic [TREE_NODES-1:0] res;
        int unsigned           node;
        int unsigned           base;
        int unsigned           span;
        int unsigned           lvl;
        res  = word;
        node = 0;
        base = 0;
        span = num_ways;
        for (lvl = 0; lvl < TREE_DEPTH; lvl++) begin
            if (span > 1) begin
                span = span / 2;
                if (|(way_oh & way_range(base + span, span))) begin
                    res[node] = PTR_LOWER;
                    node      = 2 * node + 1;
                    base      = base + span;
                end else begin
                    res[node] = PTR_UPPER;
                    node      = 2 * node + 2;
                end
            end
        end
        return res;
    endfunction

    // Walk to a one-hot victim, skipping halves with every way blocked
    function automatic logic [TREE_WAYS-1:0] tree_victim(
        input logic [TREE_NODES-1:0] word,
        input logic [TREE_WAYS-1:0]  blocked,
        input int unsigned           num_ways
    );
        logic [TREE_WAYS-1:0] upper_m;
        logic [TREE_WAYS-1:0] lower_m;
        logic                 upper_full;
        logic                 lower_full;
        logic                 go_upper;
        int unsigned          node;
        int unsigned          base;
        int unsigned          span;
        int unsigned          lvl;
        node = 0;
        base = 0;
        span = num_ways;
        for (lvl = 0; lvl < TREE_DEPTH; lvl++) begin
            if (span > 1) begin
                span       = span / 2;
                upper_m    = way_range(base + span, span);
                lower_m    = way_range(base, span);
                upper_full = (blocked & upper_m) == upper_m;
                lower_full = (blocked & lower_m) == lower_m;
                // Node bit only decides when both halves are equally usable
                if (upper_full != lower_full) begin
                    go_upper = lower_full;
                end else begin
                    go_upper = (word[node] == PTR_UPPER);
                end
                if (go_upper) begin
                    node = 2 * node + 1;
                    base = base + span;
                end else begin
                    node = 2 * node + 2;
                end
            end
        end
        return way_range(base, 1);
    endfunction

endpackage

//--- hw/plru_geom_pkg.sv
//////////////////////////////////////////////////
// Cache geometry for the PLRU replacement unit
// Default way and line counts, legal way range
//////////////////////////////////////////////////

package plru_geom_pkg;

    // Default build of the unit
    localparam int unsigned NUM_WAYS_DEF  = 8;
    localparam int unsigned NUM_LINES_DEF = 32;

    // Way count is a power of two within these limits
    localparam int unsigned MIN_WAYS = 2;
    localparam int unsigned MAX_WAYS = 64;

endpackage
